// File: exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data path width in bits.
`define EXEC_XLEN 32

// general registers. The last one doubles as the link register for calls.
`define EXEC_NUM_REGS 16

`define EXEC_IMM_BITS 12 // sign-extended immediate field.

// control-register select space. Only 0 to 3 are implemented.
`define EXEC_CR_COUNT 8

`define EXEC_SWI_OFFSET 8 // software-interrupt entry offset from the vector base.

`endif

// File: exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`EXEC_XLEN-1:0] word_t;
	typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;
	typedef logic [$clog2(`EXEC_CR_COUNT)-1:0] cr_idx_t;

	typedef enum logic [1:0] {
		CLASS_ALU    = 2'd0,
		CLASS_BRANCH = 2'd1,
		CLASS_MEM    = 2'd2,
		CLASS_MISC   = 2'd3
	} instr_class_e;

	// GCR, SCR, SWI and RFE are only valid in the misc class.
	typedef enum logic [4:0] {
		ADD   = 5'd0,  ADDC  = 5'd1,  SUB   = 5'd2,  SUBC  = 5'd3,
		MUL   = 5'd4,  LSL   = 5'd5,  LSR   = 5'd6,  ASR   = 5'd7,
		AND   = 5'd8,  OR    = 5'd9,  XOR   = 5'd10, BIC   = 5'd11,
		BST   = 5'd12, COPYA = 5'd13, COPYB = 5'd14, MOVHI = 5'd15,
		CMP   = 5'd16, GCR   = 5'd17, SCR   = 5'd18, SWI   = 5'd19,
		RFE   = 5'd20
	} alu_opc_e;

	typedef enum logic [3:0] {
		NE   = 4'd1,
		EQ   = 4'd2,
		GT   = 4'd3, // unsigned.
		LT   = 4'd4,
		GTS  = 4'd5, // signed.
		LTS  = 4'd6,
		B    = 4'd7,
		GTE  = 4'd8,
		GTES = 4'd9,
		LTES = 4'd11
	} branch_cc_e;

endpackage

// File: exec_decode.sv
`include "exec_settings.svh"

module exec_decode import exec_pkg::*; (
	input  word_t        i_instr,
	output instr_class_e o_class,
	output alu_opc_e     o_alu_opc,
	output reg_idx_t     o_rd,
	output reg_idx_t     o_ra_sel,
	output reg_idx_t     o_rb_sel,
	output word_t        o_imm,
	output logic         o_op1_pc,
	output logic         o_op2_rb,
	output logic         o_update_rd,
	output logic         o_update_flags,
	output logic         o_update_carry,
	output logic         o_is_call,
	output logic         o_mem_load,
	output logic         o_mem_store,
	output logic [1:0]   o_mem_width,
	output branch_cc_e   o_cond,
	output cr_idx_t      o_cr_sel,
	output logic         o_write_cr,
	output logic         o_is_swi,
	output logic         o_is_rfe
);

	localparam int OFS_BITS = `EXEC_IMM_BITS - 2;

	alu_opc_e opc;
	logic     mode;

	assign o_class = instr_class_e'(i_instr[31:30]);
	assign opc = alu_opc_e'(i_instr[29:25]);
	assign mode = i_instr[12];
	assign o_ra_sel = i_instr[20:17];
	assign o_rb_sel = i_instr[16:13];
	assign o_cond = branch_cc_e'(i_instr[24:21]);
	assign o_cr_sel = i_instr[2:0];
	assign o_mem_width = i_instr[11:10];

	always_comb begin
		o_rd = i_instr[24:21];
		o_imm = {{(`EXEC_XLEN-`EXEC_IMM_BITS){i_instr[`EXEC_IMM_BITS-1]}},
			i_instr[`EXEC_IMM_BITS-1:0]};
		o_alu_opc = ADD;
		o_op1_pc = 1'b0;
		o_op2_rb = 1'b0;
		o_update_rd = 1'b0;
		o_update_flags = 1'b0;
		o_update_carry = 1'b0;
		o_is_call = 1'b0;
		o_mem_load = 1'b0;
		o_mem_store = 1'b0;
		o_write_cr = 1'b0;
		o_is_swi = 1'b0;
		o_is_rfe = 1'b0;
		case (o_class)
		CLASS_ALU: begin
			if (opc inside {[ADD:CMP]}) begin
				o_alu_opc = opc;
				o_op2_rb = mode;
				o_update_rd = opc != CMP;
				o_update_flags = opc == CMP;
				o_update_carry = opc inside {ADD, ADDC, SUB, SUBC, CMP};
			end
		end
		CLASS_BRANCH: begin
			o_op1_pc = 1'b1; // target is pc + 4 + imm.
			o_is_call = mode;
			o_update_rd = mode;
			if (mode)
				o_rd = reg_idx_t'(`EXEC_NUM_REGS - 1); // calls link into the last register.
		end
		CLASS_MEM: begin
			o_imm = {{(`EXEC_XLEN-OFS_BITS){i_instr[OFS_BITS-1]}}, i_instr[OFS_BITS-1:0]};
			o_mem_store = mode;
			o_mem_load = !mode;
			o_update_rd = !mode;
		end
		default: begin
			o_alu_opc = opc inside {GCR, SCR, SWI, RFE} ? opc : ADD;
			o_update_rd = opc == GCR;
			o_write_cr = opc == SCR;
			o_is_swi = opc == SWI;
			o_is_rfe = opc == RFE;
		end
		endcase
	end

endmodule

// File: exec_regfile.sv
`include "exec_settings.svh"

module exec_regfile import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t i_ra_sel,
	input  reg_idx_t i_rb_sel,
	input  logic     i_wr_en,
	input  reg_idx_t i_wr_sel,
	input  word_t    i_wr_val,
	output word_t    o_ra,
	output word_t    o_rb
);

	word_t regs [`EXEC_NUM_REGS];

	assign o_ra = regs[i_ra_sel];
	assign o_rb = regs[i_rb_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `EXEC_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (i_wr_en) begin
			regs[i_wr_sel] <= i_wr_val;
		end
	end

	// a write-back with a floating index would corrupt an unknown register.
	a_wr_sel_known: assert property (@(posedge clk) disable iff (rst)
		i_wr_en |-> !$isunknown(i_wr_sel));

endmodule

// File: exec_alu.sv
`include "exec_settings.svh"

module exec_alu import exec_pkg::*; (
	input  alu_opc_e i_opc,
	input  word_t    i_op1,
	input  word_t    i_op2,
	input  word_t    i_cr_val,
	input  word_t    i_vector_base,
	input  word_t    i_fault_address,
	input  logic     i_carry_in,
	output word_t    o_result,
	output logic     o_carry,
	output logic     o_neg,
	output logic     o_ovf
);

	localparam int SH_BITS = $clog2(`EXEC_XLEN);
	localparam int HALF = `EXEC_XLEN / 2;

	logic [SH_BITS-1:0] sh;
	word_t              carry_word;

	assign sh = i_op2[SH_BITS-1:0];
	assign carry_word = word_t'(i_carry_in);

	always_comb begin
		o_result = '0;
		o_carry = 1'b0;
		o_neg = 1'b0;
		o_ovf = 1'b0;
		case (i_opc)
		ADD:   {o_carry, o_result} = {1'b0, i_op1} + {1'b0, i_op2};
		ADDC:  {o_carry, o_result} = {1'b0, i_op1} + {1'b0, i_op2} + {1'b0, carry_word};
		SUB:   {o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2};
		SUBC:  {o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2} - {1'b0, carry_word};
		MUL:   {o_carry, o_result} = {1'b0, i_op1} * {1'b0, i_op2};
		LSL:   {o_carry, o_result} = {1'b0, i_op1} << sh;
		LSR:   o_result = i_op1 >> sh;
		ASR:   o_result = $signed(i_op1) >>> sh;
		AND:   o_result = i_op1 & i_op2;
		OR:    o_result = i_op1 | i_op2;
		XOR:   o_result = i_op1 ^ i_op2;
		BIC:   o_result = i_op1 & ~(word_t'(1) << sh);
		BST:   o_result = i_op1 | (word_t'(1) << sh);
		COPYA: o_result = i_op1;
		COPYB: o_result = i_op2;
		MOVHI: o_result = i_op1 | {{HALF{1'b0}}, i_op2[HALF-1:0]};
		CMP: begin
			{o_carry, o_result} = {1'b0, i_op1} - {1'b0, i_op2}; // carry is the borrow.
			o_ovf = (i_op1[`EXEC_XLEN-1] ^ i_op2[`EXEC_XLEN-1]) &&
				(o_result[`EXEC_XLEN-1] == i_op2[`EXEC_XLEN-1]);
			o_neg = o_result[`EXEC_XLEN-1];
		end
		GCR:   o_result = i_cr_val;
		SCR:   o_result = i_op1;
		SWI:   o_result = i_vector_base + word_t'(`EXEC_SWI_OFFSET);
		RFE:   o_result = i_fault_address; // return address saved by the swi.
		default: o_result = '0;
		endcase
	end

endmodule

// File: exec_ctrl_regs.sv
`include "exec_settings.svh"

module exec_ctrl_regs import exec_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_commit,
	input  word_t      i_op1,
	input  word_t      i_op2,
	input  word_t      i_ra,
	input  word_t      i_pc_plus_4,
	input  logic       i_update_flags,
	input  logic       i_update_carry,
	input  logic       i_carry,
	input  logic       i_neg,
	input  logic       i_ovf,
	input  branch_cc_e i_cond,
	input  cr_idx_t    i_cr_sel,
	input  logic       i_write_cr,
	input  logic       i_is_swi,
	input  logic       i_is_rfe,
	input  cr_idx_t    i_dbg_cr_sel,
	input  word_t      i_dbg_cr_wr_val,
	input  logic       i_dbg_cr_wr_en,
	output logic       o_carry_flag,
	output logic       o_cond_met,
	output word_t      o_cr_val,
	output word_t      o_vector_base,
	output word_t      o_fault_address,
	output logic       o_irqs_enabled,
	output word_t      o_dbg_cr_val
);

	localparam int VB_LSB = 6; // vector table is 64-byte aligned.
	localparam cr_idx_t CR_VBASE = 0;
	localparam cr_idx_t CR_PSR = 1;
	localparam cr_idx_t CR_SAVED = 2;
	localparam cr_idx_t CR_FAULT = 3;

	logic                     z_flag, c_flag, n_flag, v_flag;
	logic [`EXEC_XLEN-1:VB_LSB] vector_addr;
	logic [4:0]               psr, saved_psr;
	word_t                    fault_address;
	word_t                    cr [`EXEC_CR_COUNT];
	logic                     prog_wr;

	assign psr = {o_irqs_enabled, n_flag, v_flag, c_flag, z_flag};
	assign prog_wr = i_commit && i_write_cr;

	always_comb begin
		for (int i = 0; i < `EXEC_CR_COUNT; i++)
			cr[i] = '0;
		cr[CR_VBASE] = {vector_addr, {VB_LSB{1'b0}}};
		cr[CR_PSR] = word_t'(psr);
		cr[CR_SAVED] = word_t'(saved_psr);
		cr[CR_FAULT] = fault_address;
	end

	assign o_cr_val = cr[i_cr_sel];
	assign o_dbg_cr_val = cr[i_dbg_cr_sel];
	assign o_vector_base = cr[CR_VBASE];
	assign o_fault_address = fault_address;
	assign o_carry_flag = c_flag;

	always_comb begin
		case (i_cond)
		B:    o_cond_met = 1'b1;
		NE:   o_cond_met = !z_flag;
		EQ:   o_cond_met = z_flag;
		GT:   o_cond_met = !c_flag && !z_flag;
		LT:   o_cond_met = c_flag;
		GTE:  o_cond_met = !c_flag;
		GTS:  o_cond_met = !z_flag && (n_flag == v_flag);
		LTS:  o_cond_met = n_flag != v_flag;
		GTES: o_cond_met = n_flag == v_flag;
		LTES: o_cond_met = (n_flag != v_flag) || z_flag;
		default: o_cond_met = 1'b0;
		endcase
	end

	// the debug port is checked first so it beats a program write.
	always_ff @(posedge clk) begin
		if (rst)
			vector_addr <= '0;
		else if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_VBASE)
			vector_addr <= i_dbg_cr_wr_val[`EXEC_XLEN-1:VB_LSB];
		else if (prog_wr && i_cr_sel == CR_VBASE)
			vector_addr <= i_ra[`EXEC_XLEN-1:VB_LSB];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			saved_psr <= '0;
			fault_address <= '0;
		end else begin
			if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_SAVED)
				saved_psr <= i_dbg_cr_wr_val[4:0];
			else if (i_commit && i_is_swi)
				saved_psr <= psr;
			else if (prog_wr && i_cr_sel == CR_SAVED)
				saved_psr <= i_ra[4:0];
			if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_FAULT)
				fault_address <= i_dbg_cr_wr_val;
			else if (i_commit && i_is_swi)
				fault_address <= i_pc_plus_4; // return address.
			else if (prog_wr && i_cr_sel == CR_FAULT)
				fault_address <= i_ra;
		end
	end

	// later assignments take priority over earlier ones.
	always_ff @(posedge clk) begin
		if (rst) begin
			{o_irqs_enabled, n_flag, v_flag, c_flag, z_flag} <= '0;
		end else begin
			if (i_commit && i_update_flags) begin
				z_flag <= i_op1 == i_op2;
				n_flag <= i_neg;
				v_flag <= i_ovf;
			end
			if (i_commit && i_update_carry)
				c_flag <= i_carry;
			if (i_commit && i_is_swi)
				o_irqs_enabled <= 1'b0;
			if (i_commit && i_is_rfe)
				{o_irqs_enabled, n_flag, v_flag, c_flag, z_flag} <= saved_psr;
			if (prog_wr && i_cr_sel == CR_PSR)
				{o_irqs_enabled, n_flag, v_flag, c_flag, z_flag} <= i_ra[4:0];
			if (i_dbg_cr_wr_en && i_dbg_cr_sel == CR_PSR)
				{o_irqs_enabled, n_flag, v_flag, c_flag, z_flag} <= i_dbg_cr_wr_val[4:0];
		end
	end

	a_swi_rfe_excl: assert property (@(posedge clk) disable iff (rst)
		!(i_commit && i_is_swi && i_is_rfe));

endmodule

// File: exec_stage.sv
module exec_stage import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         i_valid,
	input  logic         i_ready,
	input  word_t        i_pc,
	input  instr_class_e i_class,
	input  alu_opc_e     i_alu_opc,
	input  reg_idx_t     i_rd,
	input  reg_idx_t     i_ra_sel,
	input  reg_idx_t     i_rb_sel,
	input  word_t        i_imm,
	input  logic         i_op1_pc,
	input  logic         i_op2_rb,
	input  logic         i_update_rd,
	input  logic         i_update_flags,
	input  logic         i_update_carry,
	input  logic         i_is_call,
	input  logic         i_mem_load,
	input  logic         i_mem_store,
	input  logic [1:0]   i_mem_width,
	input  branch_cc_e   i_cond,
	input  cr_idx_t      i_cr_sel,
	input  logic         i_write_cr,
	input  logic         i_is_swi,
	input  logic         i_is_rfe,
	input  word_t        i_ra,
	input  word_t        i_rb,
	input  cr_idx_t      i_dbg_cr_sel,
	input  word_t        i_dbg_cr_wr_val,
	input  logic         i_dbg_cr_wr_en,
	output logic         o_ready,
	output logic         o_valid,
	output reg_idx_t     o_rd,
	output logic         o_wr_result,
	output word_t        o_result,
	output logic         o_branch_taken,
	output word_t        o_branch_target,
	output logic         o_mem_load,
	output logic         o_mem_store,
	output logic         o_mem_wr_en,
	output logic [1:0]   o_mem_width,
	output word_t        o_mar,
	output word_t        o_mdr,
	output word_t        o_vector_base,
	output logic         o_irqs_enabled,
	output word_t        o_dbg_cr_val,
	output logic         o_rf_wr_en,
	output reg_idx_t     o_rf_wr_sel,
	output word_t        o_rf_wr_val
);

	logic  accept, fwd_a, fwd_b;
	word_t ra_val, rb_val, op1, op2, pc_plus_4;
	word_t alu_q, cr_val, fault_address;
	logic  alu_c, alu_n, alu_o, carry_flag, cond_met;

	assign o_ready = !o_valid || i_ready;
	assign accept = i_valid && o_ready;

	// the pending result has not reached the register file yet.
	assign fwd_a = o_valid && o_wr_result && o_rd == i_ra_sel;
	assign fwd_b = o_valid && o_wr_result && o_rd == i_rb_sel;
	assign ra_val = fwd_a ? o_result : i_ra;
	assign rb_val = fwd_b ? o_result : i_rb;

	assign pc_plus_4 = i_pc + word_t'(4);
	assign op1 = i_op1_pc ? pc_plus_4 : ra_val;
	assign op2 = i_op2_rb ? rb_val : i_imm;

	assign o_rf_wr_en = o_valid && i_ready && o_wr_result;
	assign o_rf_wr_sel = o_rd;
	assign o_rf_wr_val = o_result;

	exec_alu u_alu (
		.i_opc(i_alu_opc), .i_op1(op1), .i_op2(op2), .i_cr_val(cr_val),
		.i_vector_base(o_vector_base), .i_fault_address(fault_address),
		.i_carry_in(carry_flag), .o_result(alu_q), .o_carry(alu_c),
		.o_neg(alu_n), .o_ovf(alu_o)
	);

	exec_ctrl_regs u_ctrl_regs (
		.clk, .rst, .i_commit(accept), .i_op1(op1), .i_op2(op2), .i_ra(ra_val),
		.i_pc_plus_4(pc_plus_4), .i_update_flags, .i_update_carry,
		.i_carry(alu_c), .i_neg(alu_n), .i_ovf(alu_o), .i_cond, .i_cr_sel,
		.i_write_cr, .i_is_swi, .i_is_rfe, .i_dbg_cr_sel, .i_dbg_cr_wr_val,
		.i_dbg_cr_wr_en, .o_carry_flag(carry_flag), .o_cond_met(cond_met),
		.o_cr_val(cr_val), .o_vector_base, .o_fault_address(fault_address),
		.o_irqs_enabled, .o_dbg_cr_val
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			o_valid <= 1'b0;
			o_wr_result <= 1'b0;
			o_branch_taken <= 1'b0;
			o_mem_load <= 1'b0;
			o_mem_store <= 1'b0;
			o_mem_wr_en <= 1'b0;
		end else if (accept) begin
			o_valid <= 1'b1;
			o_wr_result <= i_update_rd;
			o_branch_taken <= (i_class == CLASS_BRANCH && cond_met) || i_is_swi || i_is_rfe;
			o_mem_load <= i_mem_load;
			o_mem_store <= i_mem_store;
			o_mem_wr_en <= i_mem_store;
		end else if (i_ready) begin
			o_valid <= 1'b0; // drained with nothing new behind it.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_rd <= i_rd;
			o_result <= i_is_call ? pc_plus_4 : alu_q;
			o_branch_target <= alu_q;
			o_mem_width <= i_mem_width;
			o_mar <= alu_q;
			o_mdr <= rb_val;
		end
	end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		o_valid && !i_ready |=> o_valid && $stable({o_rd, o_wr_result, o_result,
			o_branch_taken, o_branch_target, o_mem_load, o_mem_store, o_mem_wr_en,
			o_mem_width, o_mar, o_mdr}));

endmodule

// File: exec_top.sv
module exec_top import exec_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_valid,
	input  word_t      i_instr,
	input  word_t      i_pc,
	input  logic       i_ready,
	input  cr_idx_t    i_dbg_cr_sel,
	input  word_t      i_dbg_cr_wr_val,
	input  logic       i_dbg_cr_wr_en,
	output logic       o_ready,
	output logic       o_valid,
	output reg_idx_t   o_rd,
	output logic       o_wr_result,
	output word_t      o_result,
	output logic       o_branch_taken,
	output word_t      o_branch_target,
	output logic       o_mem_load,
	output logic       o_mem_store,
	output logic       o_mem_wr_en,
	output logic [1:0] o_mem_width,
	output word_t      o_mar,
	output word_t      o_mdr,
	output word_t      o_vector_base,
	output logic       o_irqs_enabled,
	output word_t      o_dbg_cr_val
);

	instr_class_e d_class;
	alu_opc_e     d_alu_opc;
	branch_cc_e   d_cond;
	cr_idx_t      d_cr_sel;
	reg_idx_t     d_rd, d_ra_sel, d_rb_sel, rf_wr_sel;
	word_t        d_imm, rf_ra, rf_rb, rf_wr_val;
	logic [1:0]   d_mem_width;
	logic         d_op1_pc, d_op2_rb, d_update_rd, d_update_flags, d_update_carry;
	logic         d_is_call, d_mem_load, d_mem_store, d_write_cr, d_is_swi, d_is_rfe;
	logic         rf_wr_en;

	exec_decode u_decode (
		.i_instr, .o_class(d_class), .o_alu_opc(d_alu_opc), .o_rd(d_rd),
		.o_ra_sel(d_ra_sel), .o_rb_sel(d_rb_sel), .o_imm(d_imm), .o_op1_pc(d_op1_pc),
		.o_op2_rb(d_op2_rb), .o_update_rd(d_update_rd), .o_update_flags(d_update_flags),
		.o_update_carry(d_update_carry), .o_is_call(d_is_call), .o_mem_load(d_mem_load),
		.o_mem_store(d_mem_store), .o_mem_width(d_mem_width), .o_cond(d_cond),
		.o_cr_sel(d_cr_sel), .o_write_cr(d_write_cr), .o_is_swi(d_is_swi),
		.o_is_rfe(d_is_rfe)
	);

	exec_regfile u_regfile (
		.clk, .rst, .i_ra_sel(d_ra_sel), .i_rb_sel(d_rb_sel), .i_wr_en(rf_wr_en),
		.i_wr_sel(rf_wr_sel), .i_wr_val(rf_wr_val), .o_ra(rf_ra), .o_rb(rf_rb)
	);

	exec_stage u_stage (
		.clk, .rst, .i_valid, .i_ready, .i_pc, .i_class(d_class), .i_alu_opc(d_alu_opc),
		.i_rd(d_rd), .i_ra_sel(d_ra_sel), .i_rb_sel(d_rb_sel), .i_imm(d_imm),
		.i_op1_pc(d_op1_pc), .i_op2_rb(d_op2_rb), .i_update_rd(d_update_rd),
		.i_update_flags(d_update_flags), .i_update_carry(d_update_carry),
		.i_is_call(d_is_call), .i_mem_load(d_mem_load), .i_mem_store(d_mem_store),
		.i_mem_width(d_mem_width), .i_cond(d_cond), .i_cr_sel(d_cr_sel),
		.i_write_cr(d_write_cr), .i_is_swi(d_is_swi), .i_is_rfe(d_is_rfe),
		.i_ra(rf_ra), .i_rb(rf_rb), .i_dbg_cr_sel, .i_dbg_cr_wr_val, .i_dbg_cr_wr_en,
		.o_ready, .o_valid, .o_rd, .o_wr_result, .o_result, .o_branch_taken,
		.o_branch_target, .o_mem_load, .o_mem_store, .o_mem_wr_en, .o_mem_width,
		.o_mar, .o_mdr, .o_vector_base, .o_irqs_enabled, .o_dbg_cr_val,
		.o_rf_wr_en(rf_wr_en), .o_rf_wr_sel(rf_wr_sel), .o_rf_wr_val(rf_wr_val)
	);

endmodule

// File: tb_exec_top.sv
module tb_exec_top import exec_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct {
		word_t      instr;
		word_t      pc;
		word_t      result;
		reg_idx_t   rd;
		logic       wr;
		logic       taken;
		word_t      target;
		logic       chk_br;
		logic       load;
		logic       store;
		logic [1:0] width;
		word_t      mar;
		word_t      mdr;
	} row_t;

	logic       clk, rst, i_valid, i_ready, i_dbg_cr_wr_en;
	word_t      i_instr, i_pc, i_dbg_cr_wr_val;
	cr_idx_t    i_dbg_cr_sel;
	logic       o_ready, o_valid, o_wr_result, o_branch_taken;
	logic       o_mem_load, o_mem_store, o_mem_wr_en, o_irqs_enabled;
	reg_idx_t   o_rd;
	word_t      o_result, o_branch_target, o_mar, o_mdr, o_vector_base, o_dbg_cr_val;
	logic [1:0] o_mem_width;

	row_t        rows[$];
	logic [31:0] lcg_state = 32'h372f016c;

	exec_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic word_t enc(input instr_class_e cls, input logic [4:0] opc,
			input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb,
			input logic mode, input logic [11:0] imm);
		return {cls, opc, rd, ra, rb, mode, imm};
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "wait expired");
	endtask

	task automatic alu_row(input word_t instr, input word_t pc, input word_t result,
			input reg_idx_t rd, input logic wr);
		row_t r;
		r = '{instr, pc, result, rd, wr, 1'b0, '0, 1'b0, 1'b0, 1'b0, 2'b00, '0, '0};
		rows.push_back(r);
	endtask

	task automatic br_row(input word_t instr, input word_t pc, input word_t result,
			input reg_idx_t rd, input logic wr, input logic taken, input word_t target);
		row_t r;
		r = '{instr, pc, result, rd, wr, taken, target, 1'b1, 1'b0, 1'b0, 2'b00, '0, '0};
		rows.push_back(r);
	endtask

	// branch target is pc + 4 + the sign-extended immediate.
	task automatic bcc(input branch_cc_e cc, input word_t pc, input logic [11:0] imm,
			input logic taken);
		word_t tgt;
		tgt = pc + 32'd4 + {{20{imm[11]}}, imm};
		br_row(enc(CLASS_BRANCH, ADD, cc, 0, 0, 0, imm), pc, tgt, 0, 0, taken, tgt);
	endtask

	task automatic mem_row(input word_t instr, input word_t pc, input reg_idx_t rd,
			input logic store, input logic [1:0] width, input word_t mar, input word_t mdr);
		row_t r;
		r = '{instr, pc, mar, rd, !store, 1'b0, '0, 1'b0, !store, store, width, mar, mdr};
		rows.push_back(r);
	endtask

	task automatic check_row(input row_t r);
		check_word("o_result", o_result, r.result);
		check_flag("o_wr_result", o_wr_result, r.wr);
		if (r.wr)
			check_reg("o_rd", o_rd, r.rd);
		check_flag("o_branch_taken", o_branch_taken, r.taken);
		if (r.chk_br)
			check_word("o_branch_target", o_branch_target, r.target);
		check_flag("o_mem_load", o_mem_load, r.load);
		check_flag("o_mem_store", o_mem_store, r.store);
		check_flag("o_mem_wr_en", o_mem_wr_en, r.store);
		if (r.load || r.store) begin
			check_word("o_mar", o_mar, r.mar);
			check_word("o_mdr", o_mdr, r.mdr);
			check_word("o_mem_width", word_t'(o_mem_width), word_t'(r.width));
		end
	endtask

	// the held head row is compared every cycle, so a changing field fails too.
	task automatic run_rows();
		int idx;
		int got;
		int stall;
		idx = 0;
		got = 0;
		stall = 0;
		while (got < rows.size()) begin
			@(negedge clk);
			lcg_state = lcg_next(lcg_state);
			i_ready = lcg_state[31:30] != 2'b00;
			i_valid = idx < rows.size();
			if (i_valid) begin
				i_instr = rows[idx].instr;
				i_pc = rows[idx].pc;
			end
			#1;
			stall++;
			if (o_valid) begin
				check_row(rows[got]);
				if (i_ready) begin
					got++;
					stall = 0;
				end
			end
			if (i_valid && o_ready) begin
				idx++;
				stall = 0;
			end
			if (stall > 64)
				report_timeout(o_valid ? "o_ready" : "o_valid");
		end
		@(negedge clk);
		i_valid = 1'b0;
		#1;
		check_flag("o_valid after drain", o_valid, 1'b0); // no extra result.
		rows.delete();
	endtask

	task automatic dbg_write(input cr_idx_t sel, input word_t val);
		@(negedge clk);
		i_dbg_cr_sel = sel;
		i_dbg_cr_wr_val = val;
		i_dbg_cr_wr_en = 1'b1;
		@(negedge clk);
		i_dbg_cr_wr_en = 1'b0;
	endtask

	task automatic dbg_read(input cr_idx_t sel, input word_t exp);
		@(negedge clk);
		i_dbg_cr_sel = sel;
		#1;
		check_word("o_dbg_cr_val", o_dbg_cr_val, exp);
	endtask

	initial begin
		rst = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b0;
		i_instr = '0;
		i_pc = '0;
		i_dbg_cr_sel = '0;
		i_dbg_cr_wr_val = '0;
		i_dbg_cr_wr_en = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		check_flag("o_valid", o_valid, 1'b0);
		check_flag("o_wr_result", o_wr_result, 1'b0);
		check_flag("o_branch_taken", o_branch_taken, 1'b0);
		check_flag("o_mem_load", o_mem_load, 1'b0);
		check_flag("o_mem_store", o_mem_store, 1'b0);
		check_flag("o_mem_wr_en", o_mem_wr_en, 1'b0);
		check_flag("o_irqs_enabled", o_irqs_enabled, 1'b0);
		for (int i = 0; i < 4; i++)
			dbg_read(cr_idx_t'(i), '0);

		alu_row(enc(CLASS_ALU, ADD, 1, 0, 0, 0, 12'h005), 32'h100, 32'h5, 1, 1);
		alu_row(enc(CLASS_ALU, ADD, 2, 1, 0, 0, 12'hffe), 32'h104, 32'h3, 2, 1);
		alu_row(enc(CLASS_ALU, MUL, 3, 1, 2, 1, 12'h000), 32'h108, 32'hf, 3, 1);
		alu_row(enc(CLASS_ALU, LSL, 4, 3, 0, 0, 12'h004), 32'h10c, 32'hf0, 4, 1);
		alu_row(enc(CLASS_ALU, OR, 5, 4, 0, 0, 12'h00f), 32'h110, 32'hff, 5, 1);
		alu_row(enc(CLASS_ALU, XOR, 6, 5, 3, 1, 12'h000), 32'h114, 32'hf0, 6, 1);
		alu_row(enc(CLASS_ALU, BIC, 7, 5, 0, 0, 12'h000), 32'h118, 32'hfe, 7, 1);
		alu_row(enc(CLASS_ALU, BST, 8, 0, 0, 0, 12'h01f), 32'h11c, 32'h80000000, 8, 1);
		alu_row(enc(CLASS_ALU, ASR, 9, 8, 0, 0, 12'h004), 32'h120, 32'hf8000000, 9, 1);
		alu_row(enc(CLASS_ALU, LSR, 10, 8, 0, 0, 12'h004), 32'h124, 32'h08000000, 10, 1);
		alu_row(enc(CLASS_ALU, AND, 11, 9, 5, 1, 12'h000), 32'h128, 32'h0, 11, 1);
		alu_row(enc(CLASS_ALU, COPYB, 12, 0, 0, 0, 12'h800), 32'h12c, 32'hfffff800, 12, 1);
		alu_row(enc(CLASS_ALU, MOVHI, 13, 4, 0, 0, 12'h123), 32'h130, 32'h1f3, 13, 1);
		run_rows();

		// 5 against 3.
		alu_row(enc(CLASS_ALU, CMP, 0, 1, 0, 0, 12'h003), 32'h200, 32'h2, 0, 0);
		bcc(B, 32'h204, 12'hff0, 1);
		bcc(NE, 32'h208, 12'h010, 1);
		bcc(EQ, 32'h20c, 12'h010, 0);
		bcc(GT, 32'h210, 12'h010, 1);
		bcc(LT, 32'h214, 12'h010, 0);
		bcc(GTE, 32'h218, 12'h010, 1);
		bcc(GTS, 32'h21c, 12'h010, 1);
		bcc(LTS, 32'h220, 12'h010, 0);
		bcc(GTES, 32'h224, 12'h010, 1);
		bcc(LTES, 32'h228, 12'h010, 0);
		// 3 against 5.
		alu_row(enc(CLASS_ALU, CMP, 0, 2, 1, 1, 12'h000), 32'h22c, 32'hfffffffe, 0, 0);
		bcc(EQ, 32'h230, 12'h020, 0);
		bcc(GT, 32'h234, 12'h020, 0);
		bcc(LT, 32'h238, 12'h020, 1);
		bcc(GTE, 32'h23c, 12'h020, 0);
		bcc(GTS, 32'h240, 12'h020, 0);
		bcc(LTS, 32'h244, 12'h020, 1);
		bcc(LTES, 32'h248, 12'h020, 1);
		alu_row(enc(CLASS_ALU, CMP, 0, 1, 0, 0, 12'h005), 32'h24c, 32'h0, 0, 0);
		bcc(EQ, 32'h250, 12'h008, 1);
		bcc(NE, 32'h254, 12'h008, 0);
		bcc(GT, 32'h258, 12'h008, 0);
		bcc(LTES, 32'h25c, 12'h008, 1);
		// most negative word against 1 overflows.
		alu_row(enc(CLASS_ALU, CMP, 0, 8, 0, 0, 12'h001), 32'h260, 32'h7fffffff, 0, 0);
		bcc(LTS, 32'h264, 12'h008, 1);
		bcc(GT, 32'h268, 12'h008, 1);
		bcc(GTES, 32'h26c, 12'h008, 0);
		br_row(enc(CLASS_BRANCH, ADD, B, 0, 0, 1, 12'h040), 32'h280, 32'h284, 15, 1, 1,
			32'h2c4);
		alu_row(enc(CLASS_ALU, ADD, 6, 15, 0, 0, 12'h000), 32'h2c4, 32'h284, 6, 1);
		run_rows();

		alu_row(enc(CLASS_ALU, COPYB, 1, 0, 0, 0, 12'hfff), 32'h600, 32'hffffffff, 1, 1);
		alu_row(enc(CLASS_ALU, ADD, 2, 1, 0, 0, 12'h001), 32'h604, 32'h0, 2, 1);
		alu_row(enc(CLASS_ALU, ADDC, 3, 0, 0, 0, 12'h000), 32'h608, 32'h1, 3, 1);
		alu_row(enc(CLASS_ALU, ADDC, 4, 0, 0, 0, 12'h000), 32'h60c, 32'h0, 4, 1);
		alu_row(enc(CLASS_ALU, SUB, 5, 0, 0, 0, 12'h001), 32'h610, 32'hffffffff, 5, 1);
		alu_row(enc(CLASS_ALU, SUBC, 6, 0, 0, 0, 12'h000), 32'h614, 32'hffffffff, 6, 1);
		alu_row(enc(CLASS_ALU, SUBC, 7, 3, 0, 0, 12'h000), 32'h618, 32'h0, 7, 1);
		alu_row(enc(CLASS_ALU, ADDC, 8, 3, 0, 0, 12'h002), 32'h61c, 32'h3, 8, 1);
		run_rows();

		alu_row(enc(CLASS_ALU, COPYB, 10, 0, 0, 0, 12'h400), 32'h380, 32'h400, 10, 1);
		mem_row(enc(CLASS_MEM, ADD, 9, 10, 0, 0, {2'b10, 10'h010}), 32'h384, 9, 0, 2'b10,
			32'h410, 32'h0);
		alu_row(enc(CLASS_ALU, COPYB, 11, 0, 0, 0, 12'h055), 32'h388, 32'h55, 11, 1);
		mem_row(enc(CLASS_MEM, ADD, 0, 10, 11, 1, {2'b01, 10'h3fc}), 32'h38c, 0, 1, 2'b01,
			32'h3fc, 32'h55);
		mem_row(enc(CLASS_MEM, ADD, 0, 9, 8, 1, {2'b00, 10'h000}), 32'h390, 0, 1, 2'b00,
			32'h410, 32'h3);
		run_rows();

		check_flag("o_irqs_enabled", o_irqs_enabled, 1'b0);
		alu_row(enc(CLASS_ALU, COPYB, 13, 0, 0, 0, 12'h010), 32'h300, 32'h10, 13, 1);
		alu_row(enc(CLASS_MISC, SCR, 0, 13, 0, 0, 12'h001), 32'h304, 32'h10, 0, 0);
		alu_row(enc(CLASS_MISC, SCR, 0, 10, 0, 0, 12'h000), 32'h308, 32'h400, 0, 0);
		alu_row(enc(CLASS_MISC, GCR, 12, 0, 0, 0, 12'h000), 32'h30c, 32'h400, 12, 1);
		alu_row(enc(CLASS_MISC, GCR, 14, 0, 0, 0, 12'h001), 32'h310, 32'h10, 14, 1);
		br_row(enc(CLASS_MISC, SWI, 0, 0, 0, 0, 12'h000), 32'h320, 32'h408, 0, 0, 1, 32'h408);
		alu_row(enc(CLASS_MISC, GCR, 1, 0, 0, 0, 12'h001), 32'h408, 32'h0, 1, 1);
		alu_row(enc(CLASS_MISC, GCR, 2, 0, 0, 0, 12'h002), 32'h40c, 32'h10, 2, 1);
		alu_row(enc(CLASS_MISC, GCR, 3, 0, 0, 0, 12'h003), 32'h410, 32'h324, 3, 1);
		alu_row(enc(CLASS_MISC, GCR, 4, 0, 0, 0, 12'h005), 32'h414, 32'h0, 4, 1);
		br_row(enc(CLASS_MISC, RFE, 0, 0, 0, 0, 12'h000), 32'h418, 32'h324, 0, 0, 1, 32'h324);
		alu_row(enc(CLASS_MISC, GCR, 5, 0, 0, 0, 12'h001), 32'h324, 32'h10, 5, 1);
		run_rows();

		check_flag("o_irqs_enabled", o_irqs_enabled, 1'b1);
		check_word("o_vector_base", o_vector_base, 32'h400);
		dbg_read(2, 32'h10);
		dbg_write(3, 32'h12345678);
		dbg_read(3, 32'h12345678);
		dbg_write(0, 32'habcdefff);
		dbg_read(0, 32'habcdefc0); // low six bits are not stored.
		check_word("o_vector_base", o_vector_base, 32'habcdefc0);
		alu_row(enc(CLASS_MISC, GCR, 6, 0, 0, 0, 12'h003), 32'h500, 32'h12345678, 6, 1);
		br_row(enc(CLASS_MISC, SWI, 0, 0, 0, 0, 12'h000), 32'h504, 32'habcdefc8, 0, 0, 1,
			32'habcdefc8);
		alu_row(enc(CLASS_MISC, GCR, 7, 0, 0, 0, 12'h003), 32'habcdefc8, 32'h508, 7, 1);
		run_rows();
		check_flag("o_irqs_enabled", o_irqs_enabled, 1'b0);
		dbg_read(2, 32'h10);

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
exec_pkg.sv
exec_decode.sv
exec_regfile.sv
exec_alu.sv
exec_ctrl_regs.sv
exec_stage.sv
exec_top.sv
tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_top

export_include_dirs:
  - .

sources:
  - exec_pkg.sv
  - exec_decode.sv
  - exec_regfile.sv
  - exec_alu.sv
  - exec_ctrl_regs.sv
  - exec_stage.sv
  - exec_top.sv
  - target: test
    files:
      - tb_exec_top.sv
